/* dv/uart_asserts.sv */
// UART bus and line assertions
`timescale 1ns/1ps

module uart_asserts (
    input  logic                 clk_i,
    input  logic                 rst_i,
    input  logic                 cyc_i,
    input  logic                 stb_i,
    input  logic                 ack_i,
    input  logic                 tx_line_i,
    input  uart_pkg::uart_ctrl_t ctrl_i
);

    logic        tx_prev;
    logic        in_frame;
    logic [19:0] frame_pos;  // Cycle index inside the current frame
    logic [19:0] bit_len;
    logic [19:0] frame_len;
    logic        fail_seen = 1'b0;  // Set by any failing assertion

    assign bit_len   = 20'(ctrl_i.baud_div);
    assign frame_len = bit_len * 20'd10;

    // A fall outside a frame marks a start bit
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            tx_prev   <= 1'b1;
            in_frame  <= 1'b0;
            frame_pos <= '0;
        end else begin
            tx_prev <= tx_line_i;
            if (!in_frame) begin
                if (tx_prev && !tx_line_i) begin
                    in_frame  <= 1'b1;
                    frame_pos <= 20'd1;
                end
            end else if (frame_pos == frame_len - 20'd1) begin
                in_frame <= 1'b0;
            end else begin
                frame_pos <= frame_pos + 20'd1;
            end
        end
    end

    a_reset_state: assert property (@(posedge clk_i) rst_i |=> (!ack_i && tx_line_i))
        else begin
            fail_seen = 1'b1;
            $error("Bus ack or serial line wrong after reset");
        end

    a_ack_follows: assert property (@(posedge clk_i) disable iff (rst_i)
        (cyc_i && stb_i && !ack_i) |=> ack_i)
        else begin
            fail_seen = 1'b1;
            $error("Request not acknowledged on the next cycle");
        end

    a_ack_single: assert property (@(posedge clk_i) disable iff (rst_i)
        ack_i |=> !ack_i)
        else begin
            fail_seen = 1'b1;
            $error("Ack held high for two cycles");
        end

    a_no_stray_ack: assert property (@(posedge clk_i) disable iff (rst_i)
        !(cyc_i && stb_i) |=> !ack_i)
        else begin
            fail_seen = 1'b1;
            $error("Ack without a request");
        end

    a_idle_stall: assert property (@(posedge clk_i) disable iff (rst_i)
        (!ctrl_i.tx_en && tx_line_i) |=> tx_line_i)
        else begin
            fail_seen = 1'b1;
            $error("Serial line left idle while transmit disabled");
        end

    a_start_low: assert property (@(posedge clk_i) disable iff (rst_i)
        (ctrl_i.tx_en && in_frame && (frame_pos < bit_len)) |-> !tx_line_i)
        else begin
            fail_seen = 1'b1;
            $error("Start bit shorter than one bit time");
        end

    a_stop_high: assert property (@(posedge clk_i) disable iff (rst_i)
        (ctrl_i.tx_en && in_frame && (frame_pos >= frame_len - bit_len)) |-> tx_line_i)
        else begin
            fail_seen = 1'b1;
            $error("Stop bit not high");
        end

endmodule

bind uart_top uart_asserts asserts_i (
    .clk_i    (clk_i),
    .rst_i    (rst_i),
    .cyc_i    (wb_cyc_i),
    .stb_i    (wb_stb_i),
    .ack_i    (wb_ack_o),
    .tx_line_i(uart_tx_o),
    .ctrl_i   (ctrl)
);

/* dv/uart_tb.sv */
// UART peripheral testbench
`timescale 1ns/1ps

`include "uart_defs.svh"

module uart_tb;

    localparam int TEST_DIV   = 16;
    localparam int MAX_CYCLES = 20 * 10 * TEST_DIV + 2000;

    logic        clk_i;
    logic        rst_i;
    logic [3:0]  wb_adr;
    logic [31:0] wb_dat_w;
    logic        wb_we;
    logic        wb_stb;
    logic [3:0]  wb_sel;
    logic        wb_cyc;
    logic        wb_ack;
    logic [31:0] wb_dat_r;
    logic        serial_line;  // tx looped back to rx
    logic [7:0]  lfsr_q;
    logic [31:0] exp_ctrl;
    logic [7:0]  sent_q [$];
    int          cycle_cnt = 0;

    uart_top dut_i (
        .clk_i    (clk_i),
        .rst_i    (rst_i),
        .wb_adr_i (wb_adr),
        .wb_dat_i (wb_dat_w),
        .wb_we_i  (wb_we),
        .wb_stb_i (wb_stb),
        .wb_sel_i (wb_sel),
        .wb_cyc_i (wb_cyc),
        .wb_ack_o (wb_ack),
        .wb_dat_o (wb_dat_r),
        .uart_rx_i(serial_line),
        .uart_tx_o(serial_line)
    );

    initial begin
        clk_i = 1'b0;
        forever #50 clk_i = ~clk_i;
    end

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("Regression failed");
        $fatal(1, "Run stopped at first error");
    endtask

    always @(posedge clk_i) begin
        cycle_cnt <= cycle_cnt + 1;
        if (dut_i.asserts_i.fail_seen) begin
            stop_with_failure("A bound assertion on the DUT failed");
        end else if (cycle_cnt >= MAX_CYCLES) begin
            stop_with_failure($sformatf("Timeout, run still going after %0d cycles", MAX_CYCLES));
        end
    end

    task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
        assert (act === exp) else begin
            stop_with_failure($sformatf("[FAIL] %s expected 0x%08h got 0x%08h", name, exp, act));
        end
    endtask

    // Right-shift Galois form with taps 8 6 5 4
    function automatic logic [7:0] lfsr_step(input logic [7:0] s);
        return s[0] ? ((s >> 1) ^ 8'hB8) : (s >> 1);
    endfunction

    task automatic rand_byte(output logic [7:0] b);
        b = '0;
        for (int i = 0; i < 8; i++) begin
            b      = {lfsr_q[0], b[7:1]};
            lfsr_q = lfsr_step(lfsr_q);
        end
    endtask

    task automatic bus_write(input logic [3:0] adr, input logic [31:0] dat, input logic [3:0] sel);
        @(negedge clk_i);
        wb_adr   = adr;
        wb_dat_w = dat;
        wb_sel   = sel;
        wb_we    = 1'b1;
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        do begin
            @(negedge clk_i);
        end while (!wb_ack);
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic bus_read(input logic [3:0] adr, output logic [31:0] dat);
        @(negedge clk_i);
        wb_adr = adr;
        wb_sel = 4'hF;
        wb_we  = 1'b0;
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        do begin
            @(negedge clk_i);
        end while (!wb_ack);
        dat    = wb_dat_r;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
    endtask

    // Control fields change only under their byte lanes
    function automatic logic [31:0] ctrl_after_write(input logic [31:0] old,
                                                     input logic [31:0] dat,
                                                     input logic [3:0]  sel);
        logic [31:0] nxt;
        nxt = old;
        if (sel[0]) begin
            nxt[1:0] = dat[1:0];
        end
        if (sel[3] && sel[2]) begin
            nxt[31:16] = dat[31:16];
        end
        return nxt;
    endfunction

    task automatic write_ctrl(input logic [31:0] dat, input logic [3:0] sel);
        logic [31:0] rd;
        bus_write(`UART_ADR_CTRL, dat, sel);
        exp_ctrl = ctrl_after_write(exp_ctrl, dat, sel);
        bus_read(`UART_ADR_CTRL, rd);
        check_word("wb_dat_o (control)", exp_ctrl, rd);
    endtask

    task automatic wait_status(input logic [3:0] mask, input logic [3:0] value);
        logic [31:0] st;
        bus_read(`UART_ADR_STAT, st);
        while ((st[3:0] & mask) != value) begin
            bus_read(`UART_ADR_STAT, st);
        end
    endtask

    task automatic send_byte(input logic [7:0] b);
        bus_write(`UART_ADR_TXD, {24'd0, b}, 4'b0001);
        sent_q.push_back(b);
    endtask

    task automatic read_back(input int count);
        logic [31:0] rd;
        for (int i = 0; i < count; i++) begin
            wait_status(4'b1000, 4'b0000);  // Something in rx FIFO
            bus_read(`UART_ADR_RXD, rd);
            check_word("wb_dat_o (rx data)", {24'd0, sent_q.pop_front()}, rd);
        end
    endtask

    initial begin
        logic [7:0]  b;
        logic [31:0] rd;
        wb_adr   = '0;
        wb_dat_w = '0;
        wb_we    = 1'b0;
        wb_stb   = 1'b0;
        wb_sel   = '0;
        wb_cyc   = 1'b0;
        rst_i    = 1'b1;
        lfsr_q   = 8'd78;
        exp_ctrl = {`UART_BAUD_DIV_RST, 16'd0};
        repeat (4) @(negedge clk_i);
        rst_i = 1'b0;

        bus_read(`UART_ADR_STAT, rd);
        check_word("wb_dat_o (status)", 32'h0000_000A, rd);
        bus_read(`UART_ADR_CTRL, rd);
        check_word("wb_dat_o (control)", exp_ctrl, rd);

        write_ctrl({16'h1234, 14'd0, 2'b11}, 4'b0001);
        write_ctrl({16'(TEST_DIV), 14'd0, 2'b00}, 4'b1100);
        write_ctrl({16'(TEST_DIV), 14'd0, 2'b10}, 4'b1111);

        // Transmitter stalled while its queue fills up
        for (int i = 0; i < 8; i++) begin
            rand_byte(b);
            send_byte(b);
        end
        bus_read(`UART_ADR_STAT, rd);
        check_word("wb_dat_o (status)", 32'h0000_0009, rd);

        write_ctrl({16'(TEST_DIV), 14'd0, 2'b11}, 4'b1111);
        wait_status(4'b0010, 4'b0010);
        read_back(8);
        bus_read(`UART_ADR_STAT, rd);
        check_word("wb_dat_o (status)", 32'h0000_000A, rd);

        // Ten bytes into an eight byte receive FIFO
        for (int i = 0; i < 10; i++) begin
            wait_status(4'b0001, 4'b0000);
            rand_byte(b);
            send_byte(b);
        end
        wait_status(4'b0010, 4'b0010);
        repeat (11 * TEST_DIV) @(negedge clk_i);  // Last frame plus sync delay
        bus_read(`UART_ADR_STAT, rd);
        check_word("wb_dat_o (status)", 32'h0000_0006, rd);
        read_back(8);
        bus_read(`UART_ADR_STAT, rd);
        check_word("wb_dat_o (status)", 32'h0000_000A, rd);

        if (dut_i.asserts_i.fail_seen) begin
            stop_with_failure("A bound assertion on the DUT failed");
        end else begin
            $display("Regression passed");
            $finish;
        end
    end

endmodule

/* hdl/uart_defs.svh */
// UART register map and sizes
`ifndef UART_DEFS_SVH
`define UART_DEFS_SVH

// Register offsets
`define UART_ADR_CTRL 4'h0
`define UART_ADR_STAT 4'h4
`define UART_ADR_RXD  4'h8
`define UART_ADR_TXD  4'hC

// Bytes per FIFO as a power of two
`define UART_FIFO_DEPTH 8

// Divisor loaded at reset
`define UART_BAUD_DIV_RST 16'd104

`endif

/* hdl/uart_fifo.sv */
// Synchronous byte FIFO
`timescale 1ns/1ps

`include "uart_defs.svh"

module uart_fifo #(
    parameter int DEPTH = `UART_FIFO_DEPTH
) (
    input  logic       clk_i,
    input  logic       rst_i,
    input  logic       push_i,
    input  logic [7:0] data_i,
    input  logic       pop_i,
    output logic [7:0] data_o,
    output logic       full_o,
    output logic       empty_o
);

    localparam int AW = $clog2(DEPTH);

    logic [7:0]  mem [DEPTH];
    logic [AW:0] wr_ptr;
    logic [AW:0] rd_ptr;
    logic        do_push;
    logic        do_pop;

    // Extra pointer bit tells full from empty
    assign empty_o = (wr_ptr == rd_ptr);
    assign full_o  = (wr_ptr[AW] != rd_ptr[AW]) &&
                     (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

    assign do_push = push_i && !full_o;
    assign do_pop  = pop_i && !empty_o;

    assign data_o = mem[rd_ptr[AW-1:0]];  // Head of queue

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (do_push) begin
            mem[wr_ptr[AW-1:0]] <= data_i;
        end
    end

endmodule

/* hdl/uart_pkg.sv */
// UART shared types
package uart_pkg;

    // Control register fields as seen by the serial blocks
    typedef struct packed {
        logic [15:0] baud_div;  // Clock cycles per bit
        logic        rx_en;
        logic        tx_en;
    } uart_ctrl_t;

    // Same bit order as status register bits 3:0
    typedef struct packed {
        logic rx_empty;
        logic rx_full;
        logic tx_empty;
        logic tx_full;
    } uart_status_t;

    // Wishbone request from the master side
    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [3:0]  sel;
        logic [3:0]  adr;
        logic [31:0] dat;
    } wb_req_t;

endpackage

/* hdl/uart_regs.sv */
// UART Wishbone register block
`timescale 1ns/1ps

`include "uart_defs.svh"

module uart_regs (
    input  logic                   clk_i,
    input  logic                   rst_i,
    input  uart_pkg::wb_req_t      wb_i,
    output logic                   wb_ack_o,
    output logic [31:0]            wb_dat_o,
    output uart_pkg::uart_ctrl_t   ctrl_o,
    input  uart_pkg::uart_status_t status_i,
    input  logic [7:0]             rx_data_i,
    output logic                   rx_re_o,
    output logic                   tx_we_o,
    output logic [7:0]             tx_data_o
);

    import uart_pkg::*;

    uart_ctrl_t  ctrl_q;
    logic        req;
    logic        ctrl_wr;
    logic        txd_wr;
    logic        rxd_rd;
    logic [31:0] rd_word;

    // New request only while ack is low
    assign req     = wb_i.cyc && wb_i.stb && !wb_ack_o;
    assign ctrl_wr = req && wb_i.we && (wb_i.adr == `UART_ADR_CTRL);
    assign txd_wr  = req && wb_i.we && (wb_i.adr == `UART_ADR_TXD);
    assign rxd_rd  = req && !wb_i.we && (wb_i.adr == `UART_ADR_RXD);

    assign ctrl_o = ctrl_q;

    always_comb begin
        case (wb_i.adr)
            `UART_ADR_CTRL: rd_word = {ctrl_q.baud_div, 14'd0, ctrl_q.rx_en, ctrl_q.tx_en};
            `UART_ADR_STAT: rd_word = {28'd0, status_i};
            `UART_ADR_RXD:  rd_word = {24'd0, rx_data_i};  // Head before the pop
            default:        rd_word = '0;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            wb_ack_o        <= 1'b0;
            tx_we_o         <= 1'b0;
            rx_re_o         <= 1'b0;
            ctrl_q.baud_div <= `UART_BAUD_DIV_RST;
            ctrl_q.rx_en    <= 1'b0;
            ctrl_q.tx_en    <= 1'b0;
        end else begin
            wb_ack_o <= req;
            tx_we_o  <= txd_wr;  // Pulses line up with ack
            rx_re_o  <= rxd_rd;
            if (ctrl_wr && wb_i.sel[0]) begin
                ctrl_q.rx_en <= wb_i.dat[1];
                ctrl_q.tx_en <= wb_i.dat[0];
            end
            if (ctrl_wr && (&wb_i.sel[3:2])) begin
                ctrl_q.baud_div <= wb_i.dat[31:16];
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (req) begin
            wb_dat_o <= rd_word;
        end
        if (txd_wr) begin
            tx_data_o <= wb_i.dat[7:0];
        end
    end

endmodule

/* hdl/uart_rx.sv */
// UART receiver
`timescale 1ns/1ps

`include "uart_defs.svh"

module uart_rx (
    input  logic                 clk_i,
    input  logic                 rst_i,
    input  uart_pkg::uart_ctrl_t ctrl_i,
    input  logic                 rx_i,
    input  logic                 re_i,
    output logic [7:0]           data_o,
    output logic                 full_o,
    output logic                 empty_o
);

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP
    } rx_state_e;

    rx_state_e   state;
    logic        rx_meta;
    logic        rx_sync;
    logic        rx_prev;
    logic [7:0]  shift_q;
    logic [2:0]  bit_cnt;
    logic [15:0] baud_cnt;
    logic [15:0] half_div;
    logic        mid_tick;
    logic        bit_end;
    logic        fifo_push;

    uart_fifo #(
        .DEPTH(`UART_FIFO_DEPTH)
    ) rx_fifo_i (
        .clk_i  (clk_i),
        .rst_i  (rst_i),
        .push_i (fifo_push),
        .data_i (shift_q),
        .pop_i  (re_i),
        .data_o (data_o),
        .full_o (full_o),
        .empty_o(empty_o)
    );

    assign half_div = ctrl_i.baud_div >> 1;
    assign mid_tick = (baud_cnt == half_div - 16'd1);
    assign bit_end  = (baud_cnt == ctrl_i.baud_div - 16'd1);

    // Only a good stop bit pushes and a full FIFO drops the byte
    assign fifo_push = (state == RX_STOP) && bit_end && rx_sync;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
            rx_prev <= 1'b1;
        end else begin
            rx_meta <= rx_i;
            rx_sync <= rx_meta;
            rx_prev <= rx_sync;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i || !ctrl_i.rx_en) begin
            state    <= RX_IDLE;
            bit_cnt  <= '0;
            baud_cnt <= '0;
        end else begin
            baud_cnt <= baud_cnt + 16'd1;
            case (state)
                RX_IDLE: begin
                    baud_cnt <= '0;
                    if (rx_prev && !rx_sync) begin
                        state <= RX_START;
                    end
                end
                RX_START: begin
                    if (mid_tick) begin
                        baud_cnt <= '0;
                        bit_cnt  <= '0;
                        // Line back high at mid-bit means a glitch
                        state    <= rx_sync ? RX_IDLE : RX_DATA;
                    end
                end
                RX_DATA: begin
                    if (bit_end) begin
                        baud_cnt <= '0;
                        bit_cnt  <= bit_cnt + 3'd1;
                        if (bit_cnt == 3'd7) begin
                            state <= RX_STOP;
                        end
                    end
                end
                default: begin
                    if (bit_end) begin
                        state <= RX_IDLE;
                    end
                end
            endcase
        end
    end

    // LSB arrives first
    always_ff @(posedge clk_i) begin
        if (state == RX_DATA && bit_end) begin
            shift_q <= {rx_sync, shift_q[7:1]};
        end
    end

endmodule

/* hdl/uart_top.sv */
// UART peripheral top level
`timescale 1ns/1ps

module uart_top (
    input  logic        clk_i,
    input  logic        rst_i,
    input  logic [3:0]  wb_adr_i,
    input  logic [31:0] wb_dat_i,
    input  logic        wb_we_i,
    input  logic        wb_stb_i,
    input  logic [3:0]  wb_sel_i,
    input  logic        wb_cyc_i,
    output logic        wb_ack_o,
    output logic [31:0] wb_dat_o,
    input  logic        uart_rx_i,
    output logic        uart_tx_o
);

    import uart_pkg::*;

    wb_req_t      wb_req;
    uart_ctrl_t   ctrl;
    uart_status_t status;
    logic         tx_we;
    logic [7:0]   tx_data;
    logic         tx_full;
    logic         tx_empty;
    logic         rx_re;
    logic [7:0]   rx_data;
    logic         rx_full;
    logic         rx_empty;

    assign wb_req.cyc = wb_cyc_i;
    assign wb_req.stb = wb_stb_i;
    assign wb_req.we  = wb_we_i;
    assign wb_req.sel = wb_sel_i;
    assign wb_req.adr = wb_adr_i;
    assign wb_req.dat = wb_dat_i;

    assign status.rx_empty = rx_empty;
    assign status.rx_full  = rx_full;
    assign status.tx_empty = tx_empty;
    assign status.tx_full  = tx_full;

    uart_regs regs_i (
        .clk_i    (clk_i),
        .rst_i    (rst_i),
        .wb_i     (wb_req),
        .wb_ack_o (wb_ack_o),
        .wb_dat_o (wb_dat_o),
        .ctrl_o   (ctrl),
        .status_i (status),
        .rx_data_i(rx_data),
        .rx_re_o  (rx_re),
        .tx_we_o  (tx_we),
        .tx_data_o(tx_data)
    );

    uart_rx rx_i (
        .clk_i  (clk_i),
        .rst_i  (rst_i),
        .ctrl_i (ctrl),
        .rx_i   (uart_rx_i),
        .re_i   (rx_re),
        .data_o (rx_data),
        .full_o (rx_full),
        .empty_o(rx_empty)
    );

    uart_tx tx_i (
        .clk_i  (clk_i),
        .rst_i  (rst_i),
        .ctrl_i (ctrl),
        .we_i   (tx_we),
        .data_i (tx_data),
        .full_o (tx_full),
        .empty_o(tx_empty),
        .tx_o   (uart_tx_o)
    );

endmodule

/* hdl/uart_tx.sv */
// UART transmitter
`timescale 1ns/1ps

`include "uart_defs.svh"

module uart_tx (
    input  logic                clk_i,
    input  logic                rst_i,
    input  uart_pkg::uart_ctrl_t ctrl_i,
    input  logic                we_i,
    input  logic [7:0]          data_i,
    output logic                full_o,
    output logic                empty_o,
    output logic                tx_o
);

    logic [7:0]  fifo_data;
    logic        fifo_pop;
    logic        busy;
    logic [9:0]  shift_q;   // Stop, data, start
    logic [3:0]  bit_cnt;
    logic [15:0] baud_cnt;
    logic        bit_end;

    uart_fifo #(
        .DEPTH(`UART_FIFO_DEPTH)
    ) tx_fifo_i (
        .clk_i  (clk_i),
        .rst_i  (rst_i),
        .push_i (we_i),
        .data_i (data_i),
        .pop_i  (fifo_pop),
        .data_o (fifo_data),
        .full_o (full_o),
        .empty_o(empty_o)
    );

    // Only start a new frame from idle
    assign fifo_pop = !busy && ctrl_i.tx_en && !empty_o;
    assign bit_end  = (baud_cnt == ctrl_i.baud_div - 16'd1);

    assign tx_o = shift_q[0];  // Driven by a flop and high when idle

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            busy     <= 1'b0;
            shift_q  <= '1;
            bit_cnt  <= '0;
            baud_cnt <= '0;
        end else if (!busy) begin
            if (fifo_pop) begin
                busy     <= 1'b1;
                shift_q  <= {1'b1, fifo_data, 1'b0};
                bit_cnt  <= '0;
                baud_cnt <= '0;
            end
        end else if (bit_end) begin
            baud_cnt <= '0;
            shift_q  <= {1'b1, shift_q[9:1]};  // Fill with idle level
            if (bit_cnt == 4'd9) begin
                busy <= 1'b0;
            end else begin
                bit_cnt <= bit_cnt + 4'd1;
            end
        end else begin
            baud_cnt <= baud_cnt + 16'd1;
        end
    end

endmodule

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --top-module uart_tb \
    -f uart_top.f -o uart_sim &&
./obj_dir/uart_sim ||
{ echo "Simulation did not complete cleanly"; exit 1; }

/* uart_top.f */
+incdir+hdl
hdl/uart_pkg.sv
hdl/uart_fifo.sv
hdl/uart_tx.sv
hdl/uart_rx.sv
hdl/uart_regs.sv
hdl/uart_top.sv
dv/uart_asserts.sv
dv/uart_tb.sv
